// File: logic/disp_pkg.sv
// display controller shared definitions
package disp_pkg;

    ////////////////////
    // frame buffer geometry
    ////////////////////

    localparam int WORD_BITS     = 32;  // bits per buffer word
    localparam int FB_WORDS      = 384; // words in the buffer
    localparam int FB_ADDR_BITS  = 9;   // word address width
    localparam int WORDS_PER_ROW = 4;   // words across one image row

    // scaling of one bit onto the screen
    localparam int COL_REPEAT    = 2;   // columns per bit
    localparam int LINE_REPEAT   = 4;   // lines per word row

    localparam int IMG_COLS      = 256; // image width
    localparam int IMG_LINES     = 384; // image height

    ////////////////////
    // shared payloads
    ////////////////////

    // one host write, also the buffer write port
    typedef struct packed {
        logic [FB_ADDR_BITS-1:0] addr; // word address
        logic [WORD_BITS-1:0]    data; // full word, no byte lanes
    } fb_write_t;

    // one raster position, timing generator to scanout
    typedef struct packed {
        logic                         h_sync_n; // active low
        logic                         v_sync_n; // active low
        logic                         in_image; // inside the 256x384 window
        logic [$clog2(WORD_BITS)-1:0] bit_sel;  // bit index in the word
        logic [FB_ADDR_BITS-1:0]      fb_addr;  // word to fetch
    } raster_pos_t;

endpackage

// File: logic/host_write_port.sv
// host write port
`timescale 1ns/1ps

module host_write_port (
    input  logic                clk,
    input  logic                nrst,
    input  logic                host_req, // four-phase request
    input  disp_pkg::fb_write_t host_wr,  // held with req
    output logic                host_ack,
    output logic                fb_we,    // one-cycle write strobe
    output disp_pkg::fb_write_t fb_wr
);

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0, // waiting for req
        ST_WRITE = 2'd1, // payload captured
        ST_WAIT  = 2'd2  // ack high, waiting for req to drop
    } state_t;

    state_t state;
    logic   addr_ok;

    // writes past the end are acked but dropped
    assign addr_ok = (fb_wr.addr < disp_pkg::FB_WORDS);

    ////////////////////
    // handshake FSM
    ////////////////////

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state    <= ST_IDLE;
            host_ack <= 1'b0;
            fb_we    <= 1'b0;
        end else begin
            fb_we <= 1'b0; // strobe only
            case (state)
                ST_IDLE: begin
                    if (host_req) begin
                        state <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    fb_we    <= addr_ok;
                    host_ack <= 1'b1;
                    state    <= ST_WAIT;
                end
                ST_WAIT: begin
                    // a req held high just keeps ack up
                    if (!host_req) begin
                        host_ack <= 1'b0;
                        state    <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // payload register, taken on the request edge
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && host_req) begin
            fb_wr <= host_wr;
        end
    end

    ////////////////////
    // protocol checks
    ////////////////////

    // host keeps the payload steady until acked
    assert property (@(posedge clk) disable iff (!nrst)
        (host_req && !host_ack) ##1 (host_req && !host_ack) |-> $stable(host_wr))
        else $error("host_wr changed while waiting for ack");

    // write strobe only on the ack edge, so at most one cycle per request
    assert property (@(posedge clk) disable iff (!nrst)
        fb_we |-> $rose(host_ack))
        else $error("fb_we outside the ack edge");

endmodule

// File: logic/frame_buffer.sv
// frame buffer memory
`timescale 1ns/1ps

module frame_buffer (
    input  logic                              clk,
    input  logic                              fb_we,
    input  disp_pkg::fb_write_t               fb_wr,
    input  logic [disp_pkg::FB_ADDR_BITS-1:0] rd_addr, // from raster timing
    output logic [disp_pkg::WORD_BITS-1:0]    rd_data  // one cycle after rd_addr
);

    // 384 x 32, contents undefined until written
    logic [disp_pkg::WORD_BITS-1:0] mem [disp_pkg::FB_WORDS];

    ////////////////////
    // write and read ports
    ////////////////////

    always_ff @(posedge clk) begin
        if (fb_we) begin
            mem[fb_wr.addr] <= fb_wr.data;
        end
    end

    // registered read
    // same-address write in this cycle is not seen yet
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    // range filtering upstream must keep writes inside the array
    assert property (@(posedge clk)
        fb_we |-> (fb_wr.addr < disp_pkg::FB_WORDS))
        else $error("frame buffer write out of range");

endmodule

// File: logic/raster_timing.sv
// raster timing generator
`timescale 1ns/1ps

module raster_timing #(
    parameter int unsigned H_SYNC   = 46,  // cycles
    parameter int unsigned H_BACK   = 23,
    parameter int unsigned H_ACTIVE = 305,
    parameter int unsigned H_FRONT  = 8,
    parameter int unsigned V_SYNC   = 3,   // lines
    parameter int unsigned V_BACK   = 34,
    parameter int unsigned V_ACTIVE = 481,
    parameter int unsigned V_FRONT  = 11
) (
    input  logic                  clk,
    input  logic                  nrst,
    output disp_pkg::raster_pos_t pos
);

    localparam int unsigned H_TOTAL = H_SYNC + H_BACK + H_ACTIVE + H_FRONT;
    localparam int unsigned V_TOTAL = V_SYNC + V_BACK + V_ACTIVE + V_FRONT;
    localparam int          H_CW    = $clog2(H_TOTAL); // counter widths
    localparam int          V_CW    = $clog2(V_TOTAL);
    localparam int          AW      = disp_pkg::FB_ADDR_BITS;
    localparam int          SW      = $clog2(disp_pkg::WORD_BITS);

    // same order for both axes, increment wraps front porch back to sync
    typedef enum logic [1:0] {
        PH_SYNC   = 2'd0,
        PH_BACK   = 2'd1,
        PH_ACTIVE = 2'd2,
        PH_FRONT  = 2'd3
    } phase_t;

    phase_t          h_phase;
    phase_t          v_phase;
    logic [H_CW-1:0] h_cnt;    // column within phase
    logic [V_CW-1:0] v_cnt;    // line within phase
    int unsigned     h_len;
    int unsigned     v_len;
    logic            h_last;
    logic            v_last;
    logic            line_end;
    logic            in_image;
    logic [31:0]     word_idx;
    logic [31:0]     bit_idx;

    // length of the current phase
    always_comb begin
        case (h_phase)
            PH_SYNC:   h_len = H_SYNC;
            PH_BACK:   h_len = H_BACK;
            PH_ACTIVE: h_len = H_ACTIVE;
            default:   h_len = H_FRONT;
        endcase
        case (v_phase)
            PH_SYNC:   v_len = V_SYNC;
            PH_BACK:   v_len = V_BACK;
            PH_ACTIVE: v_len = V_ACTIVE;
            default:   v_len = V_FRONT;
        endcase
    end

    assign h_last   = (h_cnt + 1 == h_len);
    assign v_last   = (v_cnt + 1 == v_len);
    assign line_end = (h_phase == PH_FRONT) && h_last; // last front porch cycle

    ////////////////////
    // horizontal FSM
    ////////////////////

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            h_phase <= PH_SYNC;
            h_cnt   <= '0;
        end else if (h_last) begin
            h_phase <= phase_t'(h_phase + 2'd1);
            h_cnt   <= '0;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    ////////////////////
    // vertical FSM
    ////////////////////

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            v_phase <= PH_SYNC;
            v_cnt   <= '0;
        end else if (line_end) begin
            if (v_last) begin
                v_phase <= phase_t'(v_phase + 2'd1);
                v_cnt   <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end
    end

    ////////////////////
    // position decode
    ////////////////////

    always_comb begin
        in_image = (h_phase == PH_ACTIVE) && (v_phase == PH_ACTIVE)
                   && (h_cnt < disp_pkg::IMG_COLS) && (v_cnt < disp_pkg::IMG_LINES);
        // row of words, then word within row
        word_idx = (v_cnt / disp_pkg::LINE_REPEAT) * disp_pkg::WORDS_PER_ROW
                   + h_cnt / (disp_pkg::WORD_BITS * disp_pkg::COL_REPEAT);
        // msb shown first
        bit_idx  = disp_pkg::WORD_BITS - 1
                   - (h_cnt / disp_pkg::COL_REPEAT) % disp_pkg::WORD_BITS;

        pos.h_sync_n = (h_phase != PH_SYNC);
        pos.v_sync_n = (v_phase != PH_SYNC);
        pos.in_image = in_image;
        pos.bit_sel  = bit_idx[SW-1:0];
        pos.fb_addr  = in_image ? word_idx[AW-1:0] : '0; // keep reads in range
    end

    // active window must hold the whole image
    assert property (@(posedge clk)
        (H_ACTIVE >= disp_pkg::IMG_COLS) && (V_ACTIVE >= disp_pkg::IMG_LINES))
        else $error("active area smaller than image");

endmodule

// File: logic/pixel_scanout.sv
// pixel scanout stage
`timescale 1ns/1ps

module pixel_scanout (
    input  logic                           clk,
    input  logic                           nrst,
    input  disp_pkg::raster_pos_t          pos,
    input  logic [disp_pkg::WORD_BITS-1:0] rd_data, // lags pos by one cycle
    output logic                           h_sync_n,
    output logic                           v_sync_n,
    output logic                           pixel
);

    localparam int SW = $clog2(disp_pkg::WORD_BITS);

    logic          h_sync_q;   // stage 1, lined up with rd_data
    logic          v_sync_q;
    logic          in_image_q;
    logic [SW-1:0] bit_sel_q;

    ////////////////////
    // align with read data
    ////////////////////

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            h_sync_q   <= 1'b1; // idle high
            v_sync_q   <= 1'b1;
            in_image_q <= 1'b0;
        end else begin
            h_sync_q   <= pos.h_sync_n;
            v_sync_q   <= pos.v_sync_n;
            in_image_q <= pos.in_image;
        end
    end

    always_ff @(posedge clk) begin
        bit_sel_q <= pos.bit_sel;
    end

    ////////////////////
    // output registers
    ////////////////////

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            h_sync_n <= 1'b1;
            v_sync_n <= 1'b1;
            pixel    <= 1'b0;
        end else begin
            h_sync_n <= h_sync_q;
            v_sync_n <= v_sync_q;
            pixel    <= in_image_q & rd_data[bit_sel_q]; // blank outside image
        end
    end

endmodule

// File: logic/display_top.sv
// monochrome display controller top
`timescale 1ns/1ps

module display_top #(
    parameter int unsigned H_SYNC   = 46,  // horizontal, in cycles
    parameter int unsigned H_BACK   = 23,
    parameter int unsigned H_ACTIVE = 305,
    parameter int unsigned H_FRONT  = 8,
    parameter int unsigned V_SYNC   = 3,   // vertical, in lines
    parameter int unsigned V_BACK   = 34,
    parameter int unsigned V_ACTIVE = 481,
    parameter int unsigned V_FRONT  = 11
) (
    input  logic                clk,
    input  logic                nrst,
    input  logic                host_req,
    input  disp_pkg::fb_write_t host_wr,
    output logic                host_ack,
    output logic                h_sync_n,
    output logic                v_sync_n,
    output logic                pixel
);

    logic                           fb_we;   // write strobe
    disp_pkg::fb_write_t            fb_wr;
    disp_pkg::raster_pos_t          pos;     // current raster position
    logic [disp_pkg::WORD_BITS-1:0] rd_data;

    ////////////////////
    // host side
    ////////////////////

    host_write_port u_host_write_port (
        .clk      (clk),
        .nrst     (nrst),
        .host_req (host_req),
        .host_wr  (host_wr),
        .host_ack (host_ack),
        .fb_we    (fb_we),
        .fb_wr    (fb_wr)
    );

    frame_buffer u_frame_buffer (
        .clk     (clk),
        .fb_we   (fb_we),
        .fb_wr   (fb_wr),
        .rd_addr (pos.fb_addr),
        .rd_data (rd_data)
    );

    ////////////////////
    // video side
    ////////////////////

    raster_timing #(
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT)
    ) u_raster_timing (
        .clk  (clk),
        .nrst (nrst),
        .pos  (pos)
    );

    pixel_scanout u_pixel_scanout (
        .clk      (clk),
        .nrst     (nrst),
        .pos      (pos),
        .rd_data  (rd_data),
        .h_sync_n (h_sync_n),
        .v_sync_n (v_sync_n),
        .pixel    (pixel)
    );

endmodule

// File: sim/tb_clock.sv
// testbench clock and reset
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_NS      = 2, // 4 ns period
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic nrst
);

    initial begin
        clk = 1'b0;
        forever #(HALF_NS) clk = ~clk;
    end

    // release just after an edge, like the stimulus
    initial begin
        nrst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        nrst = 1'b1;
    end

endmodule

// File: sim/tb_checker.sv
// display output checker
`timescale 1ns/1ps

module tb_checker #(
    parameter int H_SYNC   = 46,
    parameter int H_BACK   = 23,
    parameter int H_ACTIVE = 305,
    parameter int H_FRONT  = 8,
    parameter int V_SYNC   = 3,
    parameter int V_BACK   = 34,
    parameter int V_ACTIVE = 481,
    parameter int V_FRONT  = 11
) (
    input  logic                clk,
    input  logic                nrst,
    input  logic                host_req,
    input  disp_pkg::fb_write_t host_wr,
    input  logic                host_ack,
    input  logic                h_sync_n,
    input  logic                v_sync_n,
    input  logic                pixel,
    input  logic                writes_done, // host has finished
    output logic                done,
    output int                  fail_count,
    output int                  error_count
);

    localparam int H_TOTAL   = H_SYNC + H_BACK + H_ACTIVE + H_FRONT;
    localparam int V_TOTAL   = V_SYNC + V_BACK + V_ACTIVE + V_FRONT;

    logic [disp_pkg::WORD_BITS-1:0] shadow [disp_pkg::FB_WORDS]; // mirror of the buffer

    int   err_cnt [1:6] = '{default: 0};
    int   chk_cnt [1:6] = '{default: 0};
    int   fails     = 0;
    int   errs      = 0;
    logic prev_h    = 1'b1;
    logic prev_v    = 1'b1;
    logic prev_ack  = 1'b0;
    logic prev_req  = 1'b0; // req level the DUT sees at the next edge
    logic after_rst = 1'b0; // first cycle out of reset pending
    logic h_started = 1'b0;
    logic v_started = 1'b0;
    logic checking  = 1'b0; // pixel window open
    logic done_r    = 1'b0;
    int   h_cnt     = 0;    // cycles since h_sync_n fell
    int   v_line    = 0;    // lines since v_sync_n fell
    int   v_low     = 0;
    int   frames    = 0;
    int   req_rises = 0;
    int   ack_rises = 0;

    assign done        = done_r;
    assign fail_count  = fails;
    assign error_count = errs;

    task automatic log_mismatch(input int b, input string name,
                                input logic [31:0] expv, input logic [31:0] actv);
        err_cnt[b]++;
        errs++;
        $display("[ERROR] %s: expected 0x%0h, got 0x%0h at %0t", name, expv, actv, $time);
    endtask

    task automatic raise_fault(input int b, input string msg);
        err_cnt[b]++;
        errs++;
        $display("error: %s at %0t", msg, $time);
    endtask

    task automatic report_behavior(input int b, input string title);
        if (chk_cnt[b] == 0) raise_fault(b, {title, " never got checked"});
        if (err_cnt[b] != 0) fails++;
        $display("behavior %0d %s: %0d checks, %0d errors, %s", b, title, chk_cnt[b],
                 err_cnt[b], (err_cnt[b] == 0) ? "ok" : "bad");
    endtask

    ////////////////////
    // sampling on the falling edge, all outputs settled
    ////////////////////

    always @(negedge clk) begin : sample
        logic h_fall;
        logic h_rise;
        logic v_fall;
        logic v_rise;
        int   col;
        int   line;
        int   word;
        int   bitn;
        logic exp_pix;

        h_fall = prev_h & ~h_sync_n;
        h_rise = ~prev_h & h_sync_n;
        v_fall = prev_v & ~v_sync_n;
        v_rise = ~prev_v & v_sync_n;

        if (!nrst || after_rst) begin // idle outputs in and just after reset
            chk_cnt[1] += 2;
            if (host_ack !== 1'b0) log_mismatch(1, "host_ack", 0, {31'd0, host_ack});
            if (pixel !== 1'b0) log_mismatch(1, "pixel", 0, {31'd0, pixel});
            if (nrst) report_behavior(1, "reset state");
            after_rst = !nrst;
        end

        if (nrst) begin
            // handshake, ack edges judged against the req the DUT sampled
            if (!prev_req && host_req) begin
                req_rises++;
            end
            if (!prev_ack && host_ack) begin
                ack_rises++;
                chk_cnt[2]++;
                if (!prev_req) begin
                    raise_fault(2, "host_ack rose without a request");
                end else if (host_wr.addr < disp_pkg::FB_WORDS) begin
                    shadow[host_wr.addr] = host_wr.data; // past the end is dropped
                end
            end
            if (prev_ack && !host_ack && prev_req) begin
                raise_fault(2, "host_ack fell with host_req high");
            end
            if (prev_ack && host_ack && !prev_req) begin
                raise_fault(2, "host_ack still high one cycle after host_req fell");
            end

            // horizontal, line period and sync width
            if (h_fall) begin
                if (h_started) begin
                    chk_cnt[3]++;
                    if (h_cnt + 1 != H_TOTAL) begin
                        log_mismatch(3, "h_sync_n period", H_TOTAL, h_cnt + 1);
                    end
                end
                h_started = 1'b1;
                h_cnt     = 0;
            end else if (h_started) begin
                h_cnt++;
            end
            if (h_rise && h_started) begin
                chk_cnt[3]++;
                if (h_cnt != H_SYNC) log_mismatch(3, "h_sync_n low cycles", H_SYNC, h_cnt);
            end

            // vertical, steps only at a line start
            if (v_fall && !h_fall) raise_fault(4, "v_sync_n fell away from a line start");
            if (v_fall) begin
                if (v_started) begin
                    chk_cnt[4]++;
                    if (v_line + 1 != V_TOTAL) begin
                        log_mismatch(4, "v_sync_n frame lines", V_TOTAL, v_line + 1);
                    end
                end
                v_started = 1'b1;
                v_line    = 0;
                v_low     = 0;
                if (checking) begin
                    frames++;
                    if (frames == 2) begin // two whole frames seen
                        checking = 1'b0;
                        report_behavior(3, "horizontal timing");
                        report_behavior(4, "vertical timing");
                        report_behavior(5, "image pixels");
                        report_behavior(6, "blanking");
                        done_r = 1'b1;
                    end
                end else if (writes_done && frames == 0) begin
                    checking = 1'b1;
                    if (req_rises != ack_rises) begin
                        log_mismatch(2, "host_ack count", req_rises, ack_rises);
                    end
                    report_behavior(2, "handshake");
                end
            end else if (h_fall && v_started) begin
                v_line++;
            end
            if (h_fall && v_started && !v_sync_n) v_low++;
            if (v_rise && v_started) begin
                chk_cnt[4]++;
                if (v_low != V_SYNC) log_mismatch(4, "v_sync_n low lines", V_SYNC, v_low);
            end

            // pixel against the shadow buffer
            if (h_started && v_started) begin
                col  = h_cnt - (H_SYNC + H_BACK);
                line = v_line - (V_SYNC + V_BACK);
                if (col >= 0 && col < disp_pkg::IMG_COLS && col < H_ACTIVE
                    && line >= 0 && line < disp_pkg::IMG_LINES && line < V_ACTIVE) begin
                    if (checking) begin
                        word    = (line / disp_pkg::LINE_REPEAT) * disp_pkg::WORDS_PER_ROW
                                  + col / 64;
                        bitn    = 31 - (col / disp_pkg::COL_REPEAT) % 32; // msb on the left
                        exp_pix = shadow[word[disp_pkg::FB_ADDR_BITS-1:0]][bitn[4:0]];
                        chk_cnt[5]++;
                        if (pixel !== exp_pix) begin
                            log_mismatch(5, "pixel", {31'd0, exp_pix}, {31'd0, pixel});
                        end
                    end
                end else begin
                    chk_cnt[6]++;
                    if (pixel !== 1'b0) log_mismatch(6, "pixel", 0, {31'd0, pixel});
                end
            end
        end

        prev_h   = h_sync_n;
        prev_v   = v_sync_n;
        prev_ack = host_ack;
        prev_req = host_req;
    end

endmodule

// File: sim/tb_top.sv
// display controller testbench
`timescale 1ns/1ps

module tb_top;

    // default raster timing of the DUT
    localparam int H_SYNC   = 46;
    localparam int H_BACK   = 23;
    localparam int H_ACTIVE = 305;
    localparam int H_FRONT  = 8;
    localparam int V_SYNC   = 3;
    localparam int V_BACK   = 34;
    localparam int V_ACTIVE = 481;
    localparam int V_FRONT  = 11;

    localparam int FRAME_NS    = (H_SYNC + H_BACK + H_ACTIVE + H_FRONT)
                                 * (V_SYNC + V_BACK + V_ACTIVE + V_FRONT) * 4;
    localparam int WATCHDOG_NS = 4 * FRAME_NS;
    localparam int EXTRA_WRITES = 40; // random addresses, some past the end

    logic                clk;
    logic                nrst;
    logic                host_req;
    disp_pkg::fb_write_t host_wr;
    logic                host_ack;
    logic                h_sync_n;
    logic                v_sync_n;
    logic                pixel;
    logic                writes_done;
    logic                check_done;
    int                  fail_count;
    int                  error_count;

    logic [disp_pkg::FB_ADDR_BITS-1:0] order [disp_pkg::FB_WORDS]; // fill order

    tb_clock u_tb_clock (.clk(clk), .nrst(nrst));

    display_top u_display_top (
        .clk      (clk),
        .nrst     (nrst),
        .host_req (host_req),
        .host_wr  (host_wr),
        .host_ack (host_ack),
        .h_sync_n (h_sync_n),
        .v_sync_n (v_sync_n),
        .pixel    (pixel)
    );

    tb_checker #(
        .H_SYNC (H_SYNC), .H_BACK (H_BACK), .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT),
        .V_SYNC (V_SYNC), .V_BACK (V_BACK), .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT)
    ) u_tb_checker (
        .clk         (clk),
        .nrst        (nrst),
        .host_req    (host_req),
        .host_wr     (host_wr),
        .host_ack    (host_ack),
        .h_sync_n    (h_sync_n),
        .v_sync_n    (v_sync_n),
        .pixel       (pixel),
        .writes_done (writes_done),
        .done        (check_done),
        .fail_count  (fail_count),
        .error_count (error_count)
    );

    ////////////////////
    // host stimulus
    ////////////////////

    // one four-phase write, entered and left 1 ns after an edge
    task automatic host_write(input logic [disp_pkg::FB_ADDR_BITS-1:0] addr,
                              input logic [disp_pkg::WORD_BITS-1:0] data);
        int hold;
        hold         = $urandom_range(2, 0); // req held past the ack
        host_wr.addr = addr;
        host_wr.data = data;
        host_req     = 1'b1;
        @(posedge clk);
        #1;
        while (!host_ack) begin
            @(posedge clk);
            #1;
        end
        repeat (hold) begin
            @(posedge clk);
            #1;
        end
        host_req = 1'b0;
        while (host_ack) begin // next request only after ack drops
            @(posedge clk);
            #1;
        end
    endtask

    task automatic idle_gap();
        int gap;
        gap = $urandom_range(3, 0);
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    // random permutation of all buffer addresses
    task automatic shuffle_order();
        int                                j;
        logic [disp_pkg::FB_ADDR_BITS-1:0] tmp;
        for (int i = 0; i < disp_pkg::FB_WORDS; i++) begin
            order[i] = disp_pkg::FB_ADDR_BITS'(i);
        end
        for (int i = disp_pkg::FB_WORDS - 1; i > 0; i--) begin
            j        = $urandom_range(i, 0);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
    endtask

    initial begin
        logic [31:0] r;
        host_req    = 1'b0;
        host_wr     = '0;
        writes_done = 1'b0;
        void'($urandom(94));
        wait (nrst);
        @(posedge clk);
        #1;
        shuffle_order();
        for (int i = 0; i < disp_pkg::FB_WORDS; i++) begin
            host_write(order[i], $urandom());
            idle_gap();
        end
        for (int i = 0; i < EXTRA_WRITES; i++) begin
            r = $urandom();
            host_write(r[disp_pkg::FB_ADDR_BITS-1:0], $urandom()); // 0..511
            idle_gap();
        end
        writes_done = 1'b1;
        wait (check_done);
        $display("summary: %0d behaviors passed, %0d failed, %0d errors",
                 6 - fail_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // stop a stuck run, four frames is well past the two checked ones
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run timed out after %0d ns", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: list.f
logic/disp_pkg.sv
logic/host_write_port.sv
logic/frame_buffer.sv
logic/raster_timing.sv
logic/pixel_scanout.sv
logic/display_top.sv
sim/tb_clock.sv
sim/tb_checker.sv
sim/tb_top.sv

// File: Makefile
SRCS := $(shell cat list.f)

all: run

obj_dir/Vtb_top: list.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_top -f list.f -Mdir obj_dir

run: obj_dir/Vtb_top
	./obj_dir/Vtb_top | tee /dev/stderr | grep -qx -- '>>> PASS'

clean:
	rm -rf obj_dir

.PHONY: all run clean
